// ==== hw/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  localparam int data_width     = 32;
  localparam int reg_addr_width = 5;
  localparam int shamt_width    = 5;

  // instruction word fields, bit 31 is always zero
  localparam int opcode_msb = 30;
  localparam int opcode_lsb = 25;
  localparam int rt_msb     = 24;
  localparam int rt_lsb     = 20;
  localparam int ra_msb     = 19;
  localparam int ra_lsb     = 15;
  localparam int rb_msb     = 14;
  localparam int rb_lsb     = 10;
  localparam int subop_msb  = 4;
  localparam int subop_lsb  = 0;
  localparam int imm5_msb   = 14;
  localparam int imm5_lsb   = 10;
  localparam int imm15_msb  = 14;
  localparam int imm20_msb  = 19;
  localparam int imm24_msb  = 23;

  typedef enum logic [5:0] {
    op_lwi  = 6'b000010,
    op_swi  = 6'b001010,
    op_alu1 = 6'b100000,
    op_movi = 6'b100010,
    op_j    = 6'b100100,
    op_addi = 6'b101000,
    op_xori = 6'b101011,
    op_ori  = 6'b101100
  } opcode_e;

  // sub-opcodes of op_alu1
  typedef enum logic [4:0] {
    subop_add  = 5'b00000,
    subop_sub  = 5'b00001,
    subop_and  = 5'b00010,
    subop_xor  = 5'b00011,
    subop_or   = 5'b00100,
    subop_slli = 5'b01000,
    subop_srli = 5'b01001
  } subop_e;

  typedef enum logic [2:0] {
    imm_none,
    imm5_zero,
    imm15_sign,
    imm15_zero,
    imm20_sign,
    imm24_sign
  } imm_kind_e;

endpackage

`default_nettype wire

// ==== hw/core_pkg.sv ====
`default_nettype none

package core_pkg;

  import isa_pkg::*;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    wb_alu,
    wb_load,
    wb_none
  } wb_sel_e;

  // decode to execute
  typedef struct packed {
    alu_op_e                   alu_op;
    logic                      use_imm;
    logic [data_width-1:0]     imm;
    logic [reg_addr_width-1:0] rt;
    logic                      is_load;
    logic                      is_store;
    logic                      is_jump;
    wb_sel_e                   wb_sel;
    logic [data_width-1:0]     a_data;
    // also the store data
    logic [data_width-1:0]     b_data;
    logic                      valid;
  } decode_t;

  // execute to writeback
  typedef struct packed {
    logic [data_width-1:0]     result;
    logic [reg_addr_width-1:0] rt;
    wb_sel_e                   wb_sel;
    logic                      valid;
  } exec_t;

endpackage

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
  parameter int im_addr_width = 10
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     system_enable,
  input  logic                     retire,
  input  logic                     jump_valid,
  input  logic [im_addr_width-1:0] jump_target,
  output logic                     im_enable,
  output logic                     im_read,
  output logic                     fetch_valid,
  output logic [im_addr_width-1:0] im_address
);

  logic [im_addr_width-1:0] pc;
  // idle: ready to issue, busy: one instruction in flight
  logic                     idle;
  logic                     busy;

  // a low system_enable holds the next fetch back
  assign im_read    = idle & system_enable;
  assign im_enable  = im_read;
  assign im_address = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= '0;
      idle        <= 1'b0;
      busy        <= 1'b0;
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= im_read;
      if (im_read) begin
        idle <= 1'b0;
        busy <= 1'b1;
      end else if (retire || !busy) begin
        idle <= 1'b1;
        busy <= 1'b0;
      end
      // pc moves only when the instruction completes
      if (retire) begin
        pc <= jump_valid ? jump_target : pc + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage
  import isa_pkg::*;
  import core_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      fetch_valid,
  input  logic [data_width-1:0]     instruction,
  input  logic [data_width-1:0]     read_data1,
  input  logic [data_width-1:0]     read_data2,
  output logic [reg_addr_width-1:0] read_address1,
  output logic [reg_addr_width-1:0] read_address2,
  output decode_t                   dec
);

  opcode_e                   opcode;
  subop_e                    subop;
  imm_kind_e                 imm_kind;
  alu_op_e                   alu_op;
  wb_sel_e                   wb_sel;
  logic                      use_imm;
  logic                      is_load;
  logic                      is_store;
  logic                      is_jump;
  logic [data_width-1:0]     imm;
  logic [reg_addr_width-1:0] rt;
  decode_t                   dec_next;

  assign opcode = opcode_e'(instruction[opcode_msb:opcode_lsb]);
  assign subop  = subop_e'(instruction[subop_msb:subop_lsb]);
  assign rt     = instruction[rt_msb:rt_lsb];

  // swi reads rt on port 2 as the store data
  assign read_address1 = instruction[ra_msb:ra_lsb];
  assign read_address2 = (opcode == op_swi) ? rt : instruction[rb_msb:rb_lsb];

  always_comb begin
    imm_kind = imm_none;
    alu_op   = alu_pass_b;
    wb_sel   = wb_none;
    use_imm  = 1'b0;
    is_load  = 1'b0;
    is_store = 1'b0;
    is_jump  = 1'b0;
    case (opcode)
      op_alu1: begin
        wb_sel = wb_alu;
        case (subop)
          subop_add: alu_op = alu_add;
          subop_sub: alu_op = alu_sub;
          subop_and: alu_op = alu_and;
          subop_or:  alu_op = alu_or;
          subop_xor: alu_op = alu_xor;
          subop_slli: begin
            alu_op   = alu_sll;
            use_imm  = 1'b1;
            imm_kind = imm5_zero;
          end
          subop_srli: begin
            alu_op   = alu_srl;
            use_imm  = 1'b1;
            imm_kind = imm5_zero;
          end
          // unknown sub-opcode retires as a nop
          default: wb_sel = wb_none;
        endcase
      end
      op_addi: begin
        alu_op   = alu_add;
        use_imm  = 1'b1;
        imm_kind = imm15_sign;
        wb_sel   = wb_alu;
      end
      op_ori: begin
        alu_op   = alu_or;
        use_imm  = 1'b1;
        imm_kind = imm15_zero;
        wb_sel   = wb_alu;
      end
      op_xori: begin
        alu_op   = alu_xor;
        use_imm  = 1'b1;
        imm_kind = imm15_zero;
        wb_sel   = wb_alu;
      end
      op_movi: begin
        use_imm  = 1'b1;
        imm_kind = imm20_sign;
        wb_sel   = wb_alu;
      end
      op_lwi: begin
        alu_op   = alu_add;
        use_imm  = 1'b1;
        imm_kind = imm15_sign;
        wb_sel   = wb_load;
        is_load  = 1'b1;
      end
      op_swi: begin
        alu_op   = alu_add;
        use_imm  = 1'b1;
        imm_kind = imm15_sign;
        is_store = 1'b1;
      end
      op_j: begin
        imm_kind = imm24_sign;
        is_jump  = 1'b1;
      end
      default: ;
    endcase
  end

  // immediate extension
  always_comb begin
    case (imm_kind)
      imm5_zero:  imm = {{(data_width-1-imm5_msb+imm5_lsb){1'b0}},
                         instruction[imm5_msb:imm5_lsb]};
      imm15_sign: imm = {{(data_width-1-imm15_msb){instruction[imm15_msb]}},
                         instruction[imm15_msb:0]};
      imm15_zero: imm = {{(data_width-1-imm15_msb){1'b0}}, instruction[imm15_msb:0]};
      imm20_sign: imm = {{(data_width-1-imm20_msb){instruction[imm20_msb]}},
                         instruction[imm20_msb:0]};
      imm24_sign: imm = {{(data_width-1-imm24_msb){instruction[imm24_msb]}},
                         instruction[imm24_msb:0]};
      default:    imm = '0;
    endcase
  end

  assign dec_next = '{
    alu_op:   alu_op,
    use_imm:  use_imm,
    imm:      imm,
    rt:       rt,
    is_load:  is_load,
    is_store: is_store,
    is_jump:  is_jump,
    wb_sel:   wb_sel,
    a_data:   read_data1,
    b_data:   read_data2,
    valid:    fetch_valid
  };

  always_ff @(posedge clk) begin
    if (reset) begin
      dec.valid <= 1'b0;
    end else begin
      dec <= dec_next;
    end
  end

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile
  import isa_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic [reg_addr_width-1:0] read_address1,
  input  logic [reg_addr_width-1:0] read_address2,
  input  logic                      write,
  input  logic [reg_addr_width-1:0] write_address,
  input  logic [data_width-1:0]     write_data,
  output logic [data_width-1:0]     read_data1,
  output logic [data_width-1:0]     read_data2
);

  localparam int reg_count = 2 ** reg_addr_width;

  logic [data_width-1:0] regs [reg_count];

  assign read_data1 = regs[read_address1];
  assign read_data2 = regs[read_address2];

  // r0 is an ordinary register here
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (write) begin
      regs[write_address] <= write_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage
  import isa_pkg::*;
  import core_pkg::*;
#(
  parameter int dm_addr_width = 15,
  parameter int im_addr_width = 10
) (
  input  logic                     clk,
  input  logic                     reset,
  input  decode_t                  dec,
  output exec_t                    ex,
  output logic                     dm_enable,
  output logic                     dm_read,
  output logic                     dm_write,
  output logic [dm_addr_width-1:0] dm_address,
  output logic [data_width-1:0]    dm_in,
  output logic                     jump_valid,
  output logic [im_addr_width-1:0] jump_target
);

  logic [data_width-1:0]    op_b;
  logic [data_width-1:0]    alu_result;
  // pc of the instruction now in this stage, kept in step with fetch
  logic [im_addr_width-1:0] cur_pc;
  logic [im_addr_width-1:0] branch_pc;

  assign op_b      = dec.use_imm ? dec.imm : dec.b_data;
  assign branch_pc = cur_pc + dec.imm[im_addr_width-1:0];

  always_comb begin
    case (dec.alu_op)
      alu_add: alu_result = dec.a_data + op_b;
      alu_sub: alu_result = dec.a_data - op_b;
      alu_and: alu_result = dec.a_data & op_b;
      alu_or:  alu_result = dec.a_data | op_b;
      alu_xor: alu_result = dec.a_data ^ op_b;
      alu_sll: alu_result = dec.a_data << op_b[shamt_width-1:0];
      alu_srl: alu_result = dec.a_data >> op_b[shamt_width-1:0];
      default: alu_result = op_b;
    endcase
  end

  // data memory strobes last exactly the cycle the instruction is here
  assign dm_read    = dec.valid & dec.is_load;
  assign dm_write   = dec.valid & dec.is_store;
  assign dm_enable  = dm_read | dm_write;
  assign dm_address = alu_result[dm_addr_width-1:0];
  assign dm_in      = dec.b_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      cur_pc     <= '0;
      jump_valid <= 1'b0;
      ex.valid   <= 1'b0;
    end else begin
      jump_valid <= dec.valid & dec.is_jump;
      ex <= '{
        result: alu_result,
        rt:     dec.rt,
        wb_sel: dec.wb_sel,
        valid:  dec.valid
      };
      if (dec.valid) begin
        cur_pc <= dec.is_jump ? branch_pc : cur_pc + 1'b1;
      end
    end
  end

  // target travels next to jump_valid and reaches fetch with retire
  always_ff @(posedge clk) begin
    jump_target <= branch_pc;
  end

endmodule

`default_nettype wire

// ==== hw/writeback_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_stage
  import isa_pkg::*;
  import core_pkg::*;
#(
  parameter int ins_width = 32
) (
  input  logic                      clk,
  input  logic                      reset,
  input  exec_t                     ex,
  input  logic [data_width-1:0]     dm_out,
  output logic                      reg_write,
  output logic [reg_addr_width-1:0] reg_write_addr,
  output logic [data_width-1:0]     reg_write_data,
  output logic                      retire,
  output logic [ins_width-1:0]      ins_cnt
);

  // every valid instruction retires, nops included
  assign retire         = ex.valid;
  assign reg_write      = ex.valid && (ex.wb_sel != wb_none);
  assign reg_write_addr = ex.rt;
  // load data comes straight from the memory this cycle
  assign reg_write_data = (ex.wb_sel == wb_load) ? dm_out : ex.result;

  always_ff @(posedge clk) begin
    if (reset) begin
      ins_cnt <= '0;
    end else if (retire) begin
      ins_cnt <= ins_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top
  import isa_pkg::*;
  import core_pkg::*;
#(
  parameter int im_addr_width = 10,
  parameter int dm_addr_width = 15,
  parameter int cycle_width   = 64,
  parameter int ins_width     = 32
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     system_enable,
  input  logic [data_width-1:0]    instruction,
  input  logic [data_width-1:0]    dm_out,
  output logic                     im_enable,
  output logic                     im_read,
  output logic [im_addr_width-1:0] im_address,
  output logic                     dm_enable,
  output logic                     dm_read,
  output logic                     dm_write,
  output logic [dm_addr_width-1:0] dm_address,
  output logic [data_width-1:0]    dm_in,
  output logic [cycle_width-1:0]   cycle_cnt,
  output logic [ins_width-1:0]     ins_cnt
);

  logic                      fetch_valid;
  logic                      retire;
  logic                      jump_valid;
  logic [im_addr_width-1:0]  jump_target;
  logic [reg_addr_width-1:0] read_address1;
  logic [reg_addr_width-1:0] read_address2;
  logic [data_width-1:0]     read_data1;
  logic [data_width-1:0]     read_data2;
  logic                      reg_write;
  logic [reg_addr_width-1:0] reg_write_addr;
  logic [data_width-1:0]     reg_write_data;
  decode_t                   dec;
  exec_t                     ex;

  fetch_stage #(
    .im_addr_width(im_addr_width)
  ) fetch_stage_inst (
    .clk          (clk),
    .reset        (reset),
    .system_enable(system_enable),
    .retire       (retire),
    .jump_valid   (jump_valid),
    .jump_target  (jump_target),
    .im_enable    (im_enable),
    .im_read      (im_read),
    .fetch_valid  (fetch_valid),
    .im_address   (im_address)
  );

  decode_stage decode_stage_inst (
    .clk          (clk),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .instruction  (instruction),
    .read_data1   (read_data1),
    .read_data2   (read_data2),
    .read_address1(read_address1),
    .read_address2(read_address2),
    .dec          (dec)
  );

  regfile regfile_inst (
    .clk          (clk),
    .reset        (reset),
    .read_address1(read_address1),
    .read_address2(read_address2),
    .write        (reg_write),
    .write_address(reg_write_addr),
    .write_data   (reg_write_data),
    .read_data1   (read_data1),
    .read_data2   (read_data2)
  );

  execute_stage #(
    .dm_addr_width(dm_addr_width),
    .im_addr_width(im_addr_width)
  ) execute_stage_inst (
    .clk        (clk),
    .reset      (reset),
    .dec        (dec),
    .ex         (ex),
    .dm_enable  (dm_enable),
    .dm_read    (dm_read),
    .dm_write   (dm_write),
    .dm_address (dm_address),
    .dm_in      (dm_in),
    .jump_valid (jump_valid),
    .jump_target(jump_target)
  );

  writeback_stage #(
    .ins_width(ins_width)
  ) writeback_stage_inst (
    .clk           (clk),
    .reset         (reset),
    .ex            (ex),
    .dm_out        (dm_out),
    .reg_write     (reg_write),
    .reg_write_addr(reg_write_addr),
    .reg_write_data(reg_write_data),
    .retire        (retire),
    .ins_cnt       (ins_cnt)
  );

  // free-running since reset
  always_ff @(posedge clk) begin
    if (reset) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/cpu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_checker
  import isa_pkg::*;
#(
  parameter int im_addr_width = 10,
  parameter int dm_addr_width = 15,
  parameter int cycle_width   = 64,
  parameter int ins_width     = 32
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     system_enable,
  input  logic                     im_enable,
  input  logic                     im_read,
  input  logic [im_addr_width-1:0] im_address,
  input  logic                     dm_enable,
  input  logic                     dm_read,
  input  logic                     dm_write,
  input  logic [dm_addr_width-1:0] dm_address,
  input  logic [data_width-1:0]    dm_in,
  input  logic [cycle_width-1:0]   cycle_cnt,
  input  logic [ins_width-1:0]     ins_cnt,
  input  logic                     run_done,
  output logic                     check_done,
  output int                       mismatch_cnt,
  output int                       other_cnt
);

  localparam int n_fetch = 33;
  localparam int n_store = 14;
  // the unknown opcode retires as well
  localparam int exp_ins = 33;

  typedef struct packed {
    logic [dm_addr_width-1:0] addr;
    logic [data_width-1:0]    data;
  } store_t;

  store_t                   exp_store [n_store];
  logic [im_addr_width-1:0] exp_pc [n_fetch];
  longint                   cycles;
  longint                   last_fetch;
  int                       fetch_idx;
  int                       store_idx;
  logic                     saw_low;

  initial begin
    check_done   = 1'b0;
    mismatch_cnt = 0;
    other_cnt    = 0;
    cycles       = 0;
    last_fetch   = 0;
    fetch_idx    = 0;
    store_idx    = 0;
    saw_low      = 1'b0;
    exp_store = '{
      {15'd16, 32'h0000005f},
      {15'd17, 32'h0007faf5},
      {15'd18, 32'hffff8004},
      {15'd19, 32'h0007f0e0},
      {15'd20, 32'h0007fb54},
      {15'd21, 32'h00000064},
      {15'd22, 32'h00078000},
      {15'd23, 32'h0007f0ff},
      {15'd24, 32'h00000a05},
      {15'd25, 32'hffffffb0},
      {15'd26, 32'h0000000f},
      {15'd79, 32'h0007fb54},
      {15'd43, 32'h00000123},
      {15'd44, 32'h00000123}
    };
    // straight line up to the first jump at 26
    for (int i = 0; i < 27; i++) begin
      exp_pc[i] = 10'(i);
    end
    exp_pc[27] = 10'd30;
    exp_pc[28] = 10'd28;
    exp_pc[29] = 10'd29;
    exp_pc[30] = 10'd33;
    exp_pc[31] = 10'd34;
    exp_pc[32] = 10'd35;
  end

  task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
    mismatch_cnt++;
    $display("MISMATCH time=%0t signal=%s expected=0x%0h actual=0x%0h",
             $time, name, expected, actual);
  endtask

  task automatic report_error(string what);
    other_cnt++;
    $display("ERROR time=%0t %s", $time, what);
  endtask

  task automatic check_fetch();
    if (!system_enable) begin
      report_error("im_read asserted while system_enable is low");
    end
    if (fetch_idx >= n_fetch) begin
      report_error($sformatf("extra fetch from address %0d past the program", im_address));
    end else if (im_address != exp_pc[fetch_idx]) begin
      report_mismatch("im_address", exp_pc[fetch_idx], im_address);
    end
    // a pause may only stretch the gap
    if (fetch_idx > 0) begin
      if (!saw_low && cycles - last_fetch != 4) begin
        report_mismatch("im_read spacing", 4, cycles - last_fetch);
      end else if (cycles - last_fetch < 4) begin
        report_mismatch("im_read spacing", 4, cycles - last_fetch);
      end
    end
    last_fetch = cycles;
    saw_low    = 1'b0;
    fetch_idx++;
  endtask

  task automatic check_store();
    if (cycles - last_fetch != 2) begin
      report_mismatch("dm_write delay", 2, cycles - last_fetch);
    end
    if (store_idx >= n_store) begin
      report_error($sformatf("unexpected store of 0x%0h to address %0d", dm_in, dm_address));
    end else begin
      if (dm_address != exp_store[store_idx].addr) begin
        report_mismatch("dm_address", exp_store[store_idx].addr, dm_address);
      end
      if (dm_in != exp_store[store_idx].data) begin
        report_mismatch("dm_in", exp_store[store_idx].data, dm_in);
      end
      store_idx++;
    end
  endtask

  task automatic final_checks();
    if (ins_cnt != 32'(exp_ins)) begin
      report_mismatch("ins_cnt", exp_ins, ins_cnt);
    end
    if (cycle_cnt != 64'(cycles)) begin
      report_mismatch("cycle_cnt", cycles, cycle_cnt);
    end
    if (store_idx != n_store) begin
      report_error($sformatf("only %0d of %0d expected stores were seen", store_idx, n_store));
    end
    if (fetch_idx != n_fetch) begin
      report_error($sformatf("%0d fetches seen where %0d were expected", fetch_idx, n_fetch));
    end
    check_done = 1'b1;
  endtask

  // cycles since reset release, same edges as the DUT counter
  always @(posedge clk) begin
    if (!reset) begin
      cycles <= cycles + 1;
    end
  end

  // sampled mid-cycle where all outputs are settled
  always @(negedge clk) begin
    if (!reset && !check_done) begin
      if (!system_enable) begin
        saw_low = 1'b1;
      end
      // enables go with every access and only then
      if (im_enable != im_read) begin
        report_mismatch("im_enable", im_read, im_enable);
      end
      if (dm_enable != (dm_read || dm_write)) begin
        report_mismatch("dm_enable", dm_read || dm_write, dm_enable);
      end
      if (im_read) begin
        check_fetch();
      end
      if (dm_read && cycles - last_fetch != 2) begin
        report_mismatch("dm_read delay", 2, cycles - last_fetch);
      end
      if (dm_write) begin
        check_store();
      end
      if (run_done) begin
        final_checks();
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top
  import isa_pkg::*;
();

  localparam int im_addr_width   = 10;
  localparam int dm_addr_width   = 15;
  localparam int cycle_width     = 64;
  localparam int ins_width       = 32;
  // executed instructions, skipped ones not counted
  localparam int n_exec          = 33;
  localparam int pause_after     = 10;
  localparam int pause_len       = 7;
  localparam int watchdog_cycles = 2 + n_exec * 4 + pause_len + 20;

  logic                     clk;
  logic                     reset;
  logic                     system_enable;
  logic [data_width-1:0]    instruction;
  logic [data_width-1:0]    dm_out;
  logic                     im_enable;
  logic                     im_read;
  logic [im_addr_width-1:0] im_address;
  logic                     dm_enable;
  logic                     dm_read;
  logic                     dm_write;
  logic [dm_addr_width-1:0] dm_address;
  logic [data_width-1:0]    dm_in;
  logic [cycle_width-1:0]   cycle_cnt;
  logic [ins_width-1:0]     ins_cnt;
  logic                     run_done;
  logic                     check_done;
  int                       mismatch_cnt;
  int                       other_cnt;

  logic [data_width-1:0] imem [2**im_addr_width];
  logic [data_width-1:0] dmem [2**dm_addr_width];
  logic [data_width-1:0] prog [$];

  function automatic logic [31:0] alu_word(int rt, int ra, int rb, subop_e sub);
    return {1'b0, op_alu1, 5'(rt), 5'(ra), 5'(rb), 5'b0, sub};
  endfunction

  function automatic logic [31:0] imm_word(opcode_e op, int rt, int ra, int imm);
    return {1'b0, op, 5'(rt), 5'(ra), 15'(imm)};
  endfunction

  function automatic logic [31:0] movi_word(int rt, int imm);
    return {1'b0, op_movi, 5'(rt), 20'(imm)};
  endfunction

  function automatic logic [31:0] jump_word(int offset);
    return {1'b0, op_j, 1'b0, 24'(offset)};
  endfunction

  // program table, index is the word address
  task automatic build_program();
    prog.push_back(movi_word(1, -5));
    prog.push_back(movi_word(2, 'h7f0f0));
    prog.push_back(imm_word(op_addi, 3, 1, 100));
    prog.push_back(imm_word(op_ori, 4, 2, 'h4a05));
    prog.push_back(imm_word(op_xori, 5, 1, 'h7fff));
    prog.push_back(imm_word(op_addi, 6, 2, -16));
    prog.push_back(alu_word(7, 3, 4, subop_add));
    prog.push_back(alu_word(8, 3, 1, subop_sub));
    prog.push_back(alu_word(9, 2, 5, subop_and));
    prog.push_back(alu_word(10, 3, 6, subop_or));
    prog.push_back(alu_word(11, 2, 4, subop_xor));
    prog.push_back(alu_word(12, 1, 4, subop_slli));
    prog.push_back(alu_word(13, 1, 28, subop_srli));
    // results to words 16 to 26
    for (int r = 3; r <= 13; r++) begin
      prog.push_back(imm_word(op_swi, r, 0, r + 13));
    end
    prog.push_back(imm_word(op_lwi, 14, 0, 20));
    prog.push_back(imm_word(op_swi, 14, 3, -16));
    // pc 26: forward over 27..29
    prog.push_back(jump_word(4));
    prog.push_back(imm_word(op_swi, 1, 0, 40));
    prog.push_back(movi_word(15, 'h123));
    prog.push_back(jump_word(4));
    // pc 30: back to 28
    prog.push_back(jump_word(-2));
    prog.push_back(imm_word(op_swi, 1, 0, 41));
    prog.push_back(imm_word(op_swi, 1, 0, 42));
    prog.push_back(imm_word(op_swi, 15, 0, 43));
    // unknown opcode with rt of r15, must not write it
    prog.push_back({1'b0, 6'h3f, 5'd15, 20'h12345});
    prog.push_back(imm_word(op_swi, 15, 0, 44));
  endtask

  task automatic wait_fetches(int count);
    for (int k = 0; k < count; k++) begin
      do begin
        @(posedge clk);
      end while (!im_read);
    end
  endtask

  cpu_top #(
    .im_addr_width(im_addr_width),
    .dm_addr_width(dm_addr_width),
    .cycle_width  (cycle_width),
    .ins_width    (ins_width)
  ) cpu_top_inst (
    .clk          (clk),
    .reset        (reset),
    .system_enable(system_enable),
    .instruction  (instruction),
    .dm_out       (dm_out),
    .im_enable    (im_enable),
    .im_read      (im_read),
    .im_address   (im_address),
    .dm_enable    (dm_enable),
    .dm_read      (dm_read),
    .dm_write     (dm_write),
    .dm_address   (dm_address),
    .dm_in        (dm_in),
    .cycle_cnt    (cycle_cnt),
    .ins_cnt      (ins_cnt)
  );

  cpu_checker #(
    .im_addr_width(im_addr_width),
    .dm_addr_width(dm_addr_width),
    .cycle_width  (cycle_width),
    .ins_width    (ins_width)
  ) cpu_checker_inst (
    .clk          (clk),
    .reset        (reset),
    .system_enable(system_enable),
    .im_enable    (im_enable),
    .im_read      (im_read),
    .im_address   (im_address),
    .dm_enable    (dm_enable),
    .dm_read      (dm_read),
    .dm_write     (dm_write),
    .dm_address   (dm_address),
    .dm_in        (dm_in),
    .cycle_cnt    (cycle_cnt),
    .ins_cnt      (ins_cnt),
    .run_done     (run_done),
    .check_done   (check_done),
    .mismatch_cnt (mismatch_cnt),
    .other_cnt    (other_cnt)
  );

  // both memories answer one cycle after the strobe
  always @(posedge clk) begin
    if (im_enable && im_read) begin
      instruction <= imem[im_address];
    end
    if (dm_enable && dm_read) begin
      dm_out <= dmem[dm_address];
    end
    if (dm_enable && dm_write) begin
      dmem[dm_address] <= dm_in;
    end
  end

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired before the program completed");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    reset         = 1'b1;
    system_enable = 1'b0;
    instruction   = '0;
    dm_out        = '0;
    run_done      = 1'b0;
    build_program();
    for (int a = 0; a < 2**im_addr_width; a++) begin
      imem[a] = {1'b0, 6'h3f, 15'h0, 10'(a)};
    end
    for (int a = 0; a < prog.size(); a++) begin
      imem[a] = prog[a];
    end
    for (int a = 0; a < 2**dm_addr_width; a++) begin
      dmem[a] = {16'hd00d, 1'b0, 15'(a)};
    end
    repeat (2) @(posedge clk);
    reset         <= 1'b0;
    system_enable <= 1'b1;
    wait_fetches(pause_after);
    system_enable <= 1'b0;
    repeat (pause_len) @(posedge clk);
    system_enable <= 1'b1;
    wait_fetches(n_exec - pause_after);
    // hold off any fetch past the last instruction
    system_enable <= 1'b0;
    // last instruction retires three cycles after its fetch
    repeat (4) @(posedge clk);
    run_done <= 1'b1;
    wait (check_done);
    $display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cpu_top.f ====
hw/isa_pkg.sv
hw/core_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/regfile.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/cpu_top.sv
testbench/cpu_checker.sv
testbench/tb_cpu_top.sv
